// ==== rtl/spirw_pkg.sv ====
`default_nettype none

package spirw_pkg;

    localparam int addr_bits    = 8;
    localparam int ram_depth    = 2 ** addr_bits;
    localparam int screen_w     = 64;
    localparam int screen_h     = 8;
    localparam int color_bits   = 16;
    localparam int glyph_w      = 4;
    localparam int glyph_h      = 8;
    localparam int digits       = 8;
    localparam int frame_pixels = screen_w * screen_h;
    localparam int pixel_clks   = 2 * color_bits;  // one low and one high clk per bit

    localparam logic [color_bits-1:0] fg_color = '1;  // white
    localparam logic [color_bits-1:0] bg_color = '0;  // black

    // glyph 0 first, row 0 on top, msb of a row is the leftmost pixel
    localparam logic [0:15][0:glyph_h-1][glyph_w-1:0] hex_font = {
        32'h6999_9960, 32'h2622_2270, 32'h6912_48f0, 32'h6916_1960,
        32'h1359_f110, 32'hf8e1_1960, 32'h68e9_9960, 32'hf122_4440,
        32'h6996_9960, 32'h6997_1160, 32'h699f_9990, 32'he99e_99e0,
        32'h6988_8960, 32'he999_99e0, 32'hf88e_88f0, 32'hf88e_8880
    };

    typedef enum logic [7:0] {
        cmd_write = 8'h00,
        cmd_read  = 8'h01
    } spi_cmd_e;

    typedef enum logic [1:0] {
        st_cmd,
        st_addr,
        st_data,
        st_ignore  // unknown opcode, wait for csn
    } slave_state_e;

    typedef struct packed {
        logic                 wr;
        logic [addr_bits-1:0] addr;
        logic [7:0]           wdata;
        logic                 rd;
    } ram_req_t;

    // packed so that the whole struct reads as the word b3:b2:b1:b0
    typedef struct packed {
        logic [7:0] b3;
        logic [7:0] b2;
        logic [7:0] b1;
        logic [7:0] b0;
    } display_t;

    typedef struct packed {
        logic [$clog2(screen_w)-1:0] x;
        logic [$clog2(screen_h)-1:0] y;
    } pixel_pos_t;

endpackage

`default_nettype wire

// ==== rtl/spi_rw_slave.sv ====
`default_nettype none

module spi_rw_slave
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 csn,
    input  logic                 sclk,
    input  logic                 mosi,
    output logic                 miso,
    output spirw_pkg::ram_req_t  req,
    input  logic [7:0]           rdata
);
    logic [1:0]                      csn_sr;
    logic [2:0]                      sclk_sr;
    logic [1:0]                      mosi_sr;
    logic                            active;
    logic                            sclk_rise;
    logic                            sclk_fall;
    logic [2:0]                      bit_cnt;
    logic [6:0]                      shreg;
    logic [7:0]                      rx_byte;
    logic                            byte_done;
    spirw_pkg::spi_cmd_e             cmd;
    spirw_pkg::slave_state_e         state;
    logic                            is_read;
    logic [spirw_pkg::addr_bits-1:0] addr;  // next address to access
    logic                            load_miso;
    logic [7:0]                      tx_sr;

    // pins are sampled in the clk domain, sclk needs a third stage for edges
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            csn_sr  <= '1;
            sclk_sr <= '0;
            mosi_sr <= '0;
        end
        else
        begin
            csn_sr  <= {csn_sr[0], csn};
            sclk_sr <= {sclk_sr[1:0], sclk};
            mosi_sr <= {mosi_sr[0], mosi};
        end
    end

    assign active    = !csn_sr[1];
    assign sclk_rise = sclk_sr[1] & ~sclk_sr[2];
    assign sclk_fall = ~sclk_sr[1] & sclk_sr[2];
    assign rx_byte   = {shreg, mosi_sr[1]};  // byte incl. the bit arriving now
    assign byte_done = active && sclk_rise && bit_cnt == 3'd7;
    assign cmd       = spirw_pkg::spi_cmd_e'(rx_byte);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bit_cnt <= '0;
            shreg   <= '0;
            state   <= spirw_pkg::st_cmd;
            is_read <= 1'b0;
            addr    <= '0;
            req     <= '0;
        end
        else
        begin
            req.wr <= 1'b0;  // strobes last one clk
            req.rd <= 1'b0;
            if (!active)
            begin
                bit_cnt <= '0;
                state   <= spirw_pkg::st_cmd;
            end
            else if (sclk_rise)
            begin
                bit_cnt <= bit_cnt + 3'd1;
                shreg   <= rx_byte[6:0];
            end

            if (byte_done)
            begin
                case (state)
                    spirw_pkg::st_cmd:
                    begin
                        case (cmd)
                            spirw_pkg::cmd_write: is_read <= 1'b0;
                            spirw_pkg::cmd_read:  is_read <= 1'b1;
                            default:              ;
                        endcase
                        if (cmd == spirw_pkg::cmd_write || cmd == spirw_pkg::cmd_read)
                            state <= spirw_pkg::st_addr;
                        else
                            state <= spirw_pkg::st_ignore;
                    end
                    spirw_pkg::st_addr:
                    begin
                        req.addr <= rx_byte;
                        req.rd   <= is_read;  // prefetch first read byte
                        addr     <= is_read ? rx_byte + 1'b1 : rx_byte;
                        state    <= spirw_pkg::st_data;
                    end
                    spirw_pkg::st_data:
                    begin
                        req.addr  <= addr;
                        req.wdata <= rx_byte;
                        req.wr    <= !is_read;
                        req.rd    <= is_read;
                        addr      <= addr + 1'b1;  // wraps at 255
                    end
                    default: state <= spirw_pkg::st_ignore;
                endcase
            end
        end
    end

    // rdata shows up one clk after rd, well before the next falling sclk
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            load_miso <= 1'b0;
            tx_sr     <= '0;
            miso      <= 1'b0;
        end
        else
        begin
            load_miso <= req.rd;
            if (!active)
            begin
                tx_sr <= '0;
                miso  <= 1'b0;
            end
            else if (load_miso)
                tx_sr <= rdata;
            else if (sclk_fall)
            begin
                miso  <= tx_sr[7];  // mode 0, msb first
                tx_sr <= {tx_sr[6:0], 1'b0};
            end
        end
    end

    a_wr_rd_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(req.wr && req.rd));

    // a request only comes out of a transaction that is still open on the pin
    a_no_req_idle: assert property (@(posedge clk) disable iff (!arst_n)
        (req.wr || req.rd) |-> !csn);

endmodule

`default_nettype wire

// ==== rtl/byte_ram.sv ====
`default_nettype none

module byte_ram
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  spirw_pkg::ram_req_t  req,
    output logic [7:0]           rdata,
    output spirw_pkg::display_t  disp
);
    logic [7:0] mem [spirw_pkg::ram_depth];

    always_ff @(posedge clk)
    begin
        if (req.wr)
            mem[req.addr] <= req.wdata;
        if (req.rd)
            rdata <= mem[req.addr];  // registered read, 1 clk latency
    end

    // copy of bytes 0..3 for the renderer, saves a second read port
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            disp <= '0;
        else if (req.wr)
        begin
            case (req.addr)
                'd0:     disp.b0 <= req.wdata;
                'd1:     disp.b1 <= req.wdata;
                'd2:     disp.b2 <= req.wdata;
                'd3:     disp.b3 <= req.wdata;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/hex_glyph_renderer.sv ====
`default_nettype none

module hex_glyph_renderer
(
    input  logic                             clk,
    input  logic                             arst_n,
    input  spirw_pkg::pixel_pos_t            pos,
    input  spirw_pkg::display_t              disp,
    output logic [spirw_pkg::color_bits-1:0] color
);
    logic [$clog2(spirw_pkg::digits)-1:0]  digit;
    logic [$clog2(spirw_pkg::digits)-1:0]  nib_sel;
    logic [2:0]                            col;      // column inside the 8 wide cell
    logic [$clog2(spirw_pkg::glyph_h)-1:0] font_row;
    logic [31:0]                           word;
    logic [3:0]                            nibble;
    logic [spirw_pkg::glyph_w-1:0]         row_bits;
    logic                                  pix_on;

    assign digit    = pos.x[5:3];
    assign col      = pos.x[2:0];
    assign font_row = pos.y;  // glyph is as tall as the screen
    assign word     = disp;   // b3:b2:b1:b0

    // leftmost digit is the top nibble of b3
    assign nib_sel  = 3'(spirw_pkg::digits - 1) - digit;
    assign nibble   = word[{nib_sel, 2'b00} +: 4];
    assign row_bits = spirw_pkg::hex_font[nibble][font_row];

    // right half of a cell is spacing
    assign pix_on = (col < spirw_pkg::glyph_w)
                  && row_bits[2'(spirw_pkg::glyph_w - 1) - col[1:0]];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            color <= spirw_pkg::bg_color;
        else
            color <= pix_on ? spirw_pkg::fg_color : spirw_pkg::bg_color;
    end

    a_row_in_screen: assert property (@(posedge clk) disable iff (!arst_n)
        pos.y <= spirw_pkg::screen_h - 1);

endmodule

`default_nettype wire

// ==== rtl/lcd_pixel_shifter.sv ====
`default_nettype none

module lcd_pixel_shifter
(
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [spirw_pkg::color_bits-1:0] color,
    output spirw_pkg::pixel_pos_t            pos,
    output logic                             lcd_csn,
    output logic                             lcd_clk,
    output logic                             lcd_mosi,
    output logic                             lcd_dc
);
    logic [$clog2(spirw_pkg::pixel_clks)-1:0]   phase;    // clk inside a pixel slot
    logic [$clog2(spirw_pkg::frame_pixels)-1:0] pix_idx;
    logic [spirw_pkg::color_bits-1:0]           shreg;
    logic                                       last_phase;
    logic                                       frame_end;
    logic                                       gap_next;

    // lcd_csn doubles as the gap flag
    assign last_phase = phase == spirw_pkg::pixel_clks - 1;
    assign frame_end  = last_phase && !lcd_csn && pix_idx == spirw_pkg::frame_pixels - 1;
    assign gap_next   = frame_end || (lcd_csn && !last_phase);

    assign lcd_mosi = shreg[spirw_pkg::color_bits-1];
    assign lcd_dc   = 1'b1;  // pixel data only

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            phase   <= '0;
            pix_idx <= '0;
            lcd_csn <= 1'b1;  // start in the gap slot
            lcd_clk <= 1'b1;
            shreg   <= '0;
            pos     <= '0;
        end
        else
        begin
            phase   <= phase + 1'b1;
            lcd_csn <= gap_next;
            lcd_clk <= gap_next | ~phase[0];  // low on even phases

            if (last_phase && !lcd_csn)
                pix_idx <= pix_idx + 1'b1;

            // bit changes while lcd_clk is low
            if (last_phase)
                shreg <= color;
            else if (phase[0])
                shreg <= shreg << 1;

            // issue the next position 2 clk ahead of its first bit
            if (phase == spirw_pkg::pixel_clks - 3)
            begin
                if (lcd_csn)
                    pos <= '0;
                else if (pos.x == 6'(spirw_pkg::screen_w - 1))
                begin
                    pos.x <= '0;
                    pos.y <= pos.y + 1'b1;
                end
                else
                    pos.x <= pos.x + 1'b1;
            end
        end
    end

    a_clk_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
        lcd_csn |-> lcd_clk);

endmodule

`default_nettype wire

// ==== rtl/spirw_hex_top.sv ====
`default_nettype none

module spirw_hex_top
(
    input  logic clk,
    input  logic arst_n,
    input  logic spi_csn,
    input  logic spi_sclk,
    input  logic spi_mosi,
    output logic spi_miso,
    output logic lcd_csn,
    output logic lcd_clk,
    output logic lcd_mosi,
    output logic lcd_dc
);
    spirw_pkg::ram_req_t              ram_req;
    spirw_pkg::display_t              disp;
    spirw_pkg::pixel_pos_t            pos;
    logic [7:0]                       ram_rdata;
    logic [spirw_pkg::color_bits-1:0] color;

    // external master writes and reads the ram
    spi_rw_slave spi_rw_slave_inst
    (
        .clk    (clk),
        .arst_n (arst_n),
        .csn    (spi_csn),
        .sclk   (spi_sclk),
        .mosi   (spi_mosi),
        .miso   (spi_miso),
        .req    (ram_req),
        .rdata  (ram_rdata)
    );

    byte_ram byte_ram_inst
    (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (ram_req),
        .rdata  (ram_rdata),
        .disp   (disp)
    );

    hex_glyph_renderer hex_glyph_renderer_inst
    (
        .clk    (clk),
        .arst_n (arst_n),
        .pos    (pos),
        .disp   (disp),
        .color  (color)
    );

    lcd_pixel_shifter lcd_pixel_shifter_inst
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .color    (color),
        .pos      (pos),
        .lcd_csn  (lcd_csn),
        .lcd_clk  (lcd_clk),
        .lcd_mosi (lcd_mosi),
        .lcd_dc   (lcd_dc)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen
(
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial
    begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;  // released just after an edge
    end

endmodule

`default_nettype wire

// ==== verification/spirw_hex_tb.sv ====
`default_nettype none

module spirw_hex_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        arst_n;
    logic        spi_csn;
    logic        spi_sclk;
    logic        spi_mosi;
    logic        spi_miso;
    logic        lcd_csn;
    logic        lcd_clk;
    logic        lcd_mosi;
    logic        lcd_dc;

    logic [31:0] rng_state = 32'hf2c3_ac14;
    logic [7:0]  model_mem [256];
    logic [31:0] model_word;           // expected b3:b2:b1:b0
    logic [7:0]  tx_q [$];
    logic [7:0]  rx_q [$];
    logic        rd_done;
    logic [7:0]  rd_exp;
    logic [7:0]  rd_val;

    // lcd stream decoder state
    logic        lcd_csn_q;
    logic        lcd_clk_q;
    logic [3:0]  bit_cnt;
    int          pix_cnt;
    int          frame_bits;
    logic [15:0] shift;
    logic [31:0] frame_word;
    logic        frame_clean;          // no spi traffic during this frame
    logic        pixel_done;
    logic        frame_done;
    logic [15:0] pixel_val;
    logic [15:0] pixel_exp;

    tb_clock_gen clock_gen_inst
    (
        .clk    (clk),
        .arst_n (arst_n)
    );

    spirw_hex_top DUT
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .spi_csn  (spi_csn),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .lcd_csn  (lcd_csn),
        .lcd_clk  (lcd_clk),
        .lcd_mosi (lcd_mosi),
        .lcd_dc   (lcd_dc)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // pixel idx of a frame showing word where digit k is nibble 7-k
    function automatic logic [15:0] expected_color(input logic [31:0] word, input int idx);
        int         x;
        int         y;
        int         digit;
        logic [3:0] nib;
        x     = idx % spirw_pkg::screen_w;
        y     = idx / spirw_pkg::screen_w;
        digit = x / 8;
        nib   = word[(spirw_pkg::digits - 1 - digit) * 4 +: 4];
        if (x % 8 >= spirw_pkg::glyph_w)
            return spirw_pkg::bg_color;  // spacing columns
        if (spirw_pkg::hex_font[nib][y][spirw_pkg::glyph_w - 1 - x % 8])
            return spirw_pkg::fg_color;
        return spirw_pkg::bg_color;
    endfunction

    function automatic int watchdog_ns();
        int frame_ns;
        int byte_ns;
        frame_ns = (spirw_pkg::frame_pixels + 1) * spirw_pkg::pixel_clks * 20;
        byte_ns  = 8 * 2 * 5 * 20;  // 8 bits of two 5 clk halves each
        return 6 * frame_ns + 64 * byte_ns;
    endfunction

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] %s expected %h actual %h", name, exp, act);
        abort_run();
    endtask

    // mode 0 master sending tx_q and collecting miso bytes into rx_q
    task automatic spi_transaction();
        logic [7:0] rx;
        int         k;
        int         i;
        rx_q    = {};
        spi_csn = 1'b0;
        for (k = 0; k < tx_q.size(); k++)
        begin
            for (i = 7; i >= 0; i--)
            begin
                spi_mosi = tx_q[k][i];
                repeat (5) @(posedge clk);
                #1 spi_sclk = 1'b1;
                rx[i] = spi_miso;  // sampled on the rise
                repeat (5) @(posedge clk);
                #1 spi_sclk = 1'b0;
            end
            rx_q.push_back(rx);
        end
        repeat (5) @(posedge clk);
        #1 spi_csn = 1'b1;
        repeat (5) @(posedge clk);
        #1;
    endtask

    task automatic spi_write(input logic [7:0] addr, input int n);
        logic [31:0] rnd;
        int          k;
        tx_q = {spirw_pkg::cmd_write, addr};
        for (k = 0; k < n; k++)
        begin
            rnd = next_random();
            tx_q.push_back(rnd[31:24]);
            model_mem[8'(addr + k)] = rnd[31:24];  // wraps like the slave
        end
        model_word = {model_mem[3], model_mem[2], model_mem[1], model_mem[0]};
        spi_transaction();
    endtask

    task automatic spi_read(input logic [7:0] addr, input int n);
        int k;
        tx_q = {spirw_pkg::cmd_read, addr};
        for (k = 0; k < n; k++)
            tx_q.push_back(8'h00);
        spi_transaction();
        for (k = 0; k < n; k++)
        begin
            rd_exp  = model_mem[8'(addr + k)];
            rd_val  = rx_q[k + 2];
            rd_done = 1'b1;
            @(posedge clk);
            #1 rd_done = 1'b0;
        end
    endtask

    task automatic wait_frames(input int n);
        repeat (n) @(posedge lcd_csn);
        repeat (3) @(posedge clk);  // last pixel and frame length get checked
        #1;
    endtask

    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            lcd_csn_q   <= 1'b1;
            lcd_clk_q   <= 1'b1;
            bit_cnt     <= '0;
            pix_cnt     <= 0;
            frame_bits  <= 0;
            shift       <= '0;
            frame_word  <= '0;
            frame_clean <= 1'b0;
            pixel_done  <= 1'b0;
            frame_done  <= 1'b0;
            pixel_val   <= '0;
            pixel_exp   <= '0;
        end
        else
        begin
            lcd_csn_q  <= lcd_csn;
            lcd_clk_q  <= lcd_clk;
            pixel_done <= 1'b0;
            frame_done <= lcd_csn && !lcd_csn_q;
            if (!lcd_csn && lcd_csn_q)
            begin
                bit_cnt     <= '0;  // positions count from the fall of lcd_csn
                pix_cnt     <= 0;
                frame_bits  <= 0;
                frame_word  <= model_word;
                frame_clean <= spi_csn;
            end
            else
            begin
                if (!spi_csn)
                    frame_clean <= 1'b0;
                if (!lcd_csn && lcd_clk && !lcd_clk_q)
                begin
                    shift      <= {shift[14:0], lcd_mosi};
                    frame_bits <= frame_bits + 1;
                    bit_cnt    <= bit_cnt + 1'b1;
                    if (bit_cnt == 4'd15)
                    begin
                        pixel_done <= 1'b1;
                        pixel_val  <= {shift[14:0], lcd_mosi};
                        pixel_exp  <= expected_color(frame_word, pix_cnt);
                        pix_cnt    <= pix_cnt + 1;
                    end
                end
            end
        end
    end

    a_reset_state: assert property (@(posedge clk)
        $rose(arst_n) |-> lcd_csn && lcd_clk && lcd_dc && !spi_miso)
        else fail_value("reset_state", 32'b1110,
                        $sampled({lcd_csn, lcd_clk, lcd_dc, spi_miso}));

    a_pixel: assert property (@(posedge clk) disable iff (!arst_n)
        pixel_done && frame_clean |-> pixel_val == pixel_exp)
        else fail_value("frame_pixel", $sampled(pixel_exp), $sampled(pixel_val));

    a_frame_bits: assert property (@(posedge clk) disable iff (!arst_n)
        frame_done |-> frame_bits == spirw_pkg::frame_pixels * spirw_pkg::color_bits)
        else fail_value("frame_bits", spirw_pkg::frame_pixels * spirw_pkg::color_bits,
                        $sampled(frame_bits));

    a_gap_clk: assert property (@(posedge clk) disable iff (!arst_n)
        lcd_csn |-> lcd_clk)
        else fail_value("gap_clk", 1, $sampled(lcd_clk));

    a_dc_high: assert property (@(posedge clk) disable iff (!arst_n)
        lcd_dc)
        else fail_value("lcd_dc", 1, $sampled(lcd_dc));

    a_read_back: assert property (@(posedge clk) disable iff (!arst_n)
        rd_done |-> rd_val == rd_exp)
        else fail_value("read_back", $sampled(rd_exp), $sampled(rd_val));

    initial
    begin : watchdog
        int limit_ns;
        limit_ns = watchdog_ns();
        #(limit_ns);
        $display("watchdog timeout, the stimulus did not finish in time");
        abort_run();
    end

    initial
    begin
        spi_csn    = 1'b1;
        spi_sclk   = 1'b0;
        spi_mosi   = 1'b0;
        rd_done    = 1'b0;
        rd_exp     = '0;
        rd_val     = '0;
        model_word = '0;
        foreach (model_mem[a])
            model_mem[a] = '0;
        @(posedge arst_n);
        @(posedge clk);
        #1;
        wait_frames(1);       // first frame shows 00000000
        spi_write(8'd0, 4);
        wait_frames(2);       // one dirty frame and then a clean one
        spi_write(8'd250, 7); // 250..255 and wrap to 0
        spi_write(8'd10, 1);
        tx_q = {8'h5a, 8'd2};  // unknown opcode aimed at display bytes 2 and 3
        repeat (2)
            tx_q.push_back(8'hc3);
        spi_transaction();
        spi_read(8'd250, 10);
        spi_read(8'd10, 1);
        wait_frames(2);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/spirw_pkg.sv
rtl/spi_rw_slave.sv
rtl/byte_ram.sv
rtl/hex_glyph_renderer.sv
rtl/lcd_pixel_shifter.sv
rtl/spirw_hex_top.sv
verification/tb_clock_gen.sv
verification/spirw_hex_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator and run, exit status is the simulation result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module spirw_hex_tb -f files.f -o spirw_hex_sim
./obj_dir/spirw_hex_sim
